//--- nic_irq_config.svh
////////////////////////////////////////////////////////////////////////////
// widths and intervals shared by the interrupt block and its testbench
// the resend interval must fit in the resend counter width
////////////////////////////////////////////////////////////////////////////

`ifndef NIC_IRQ_CONFIG_SVH
`define NIC_IRQ_CONFIG_SVH

// pending-completion counter per source, saturates at 255
`define IRQ_CNT_W 8

// idle cycles before a repeat interrupt is requested
`define IRQ_RESEND_CYCLES 64

// resend counter width
`define IRQ_TMR_W 8

`endif

//--- irq_types_pkg.sv
////////////////////////////////////////////////////////////////////////////
// controller enums, shared by the RTL and the testbench
////////////////////////////////////////////////////////////////////////////

package irq_types_pkg;

    // interrupt source, also used as the vector
    typedef enum logic {
        SRC_RX = 1'b0,
        SRC_TX = 1'b1
    } irq_src_e;

    // interrupt generator FSM
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,  // wait for condition or resend
        ST_CHECK    = 2'd1,  // condition taken, test enable
        ST_WAIT_RDY = 2'd2,  // request out, wait for host core
        ST_RESEND   = 2'd3   // resend taken, wait for enable
    } irq_state_e;

endpackage

//--- irq_host_pkg.sv
////////////////////////////////////////////////////////////////////////////
// structs on the DMA event, host command and interrupt ports
// counts are `IRQ_CNT_W wide, an event count is at least 1
////////////////////////////////////////////////////////////////////////////

`include "nic_irq_config.svh"

package irq_host_pkg;
    import irq_types_pkg::*;

    typedef enum logic [1:0] {
        OP_NOP     = 2'd0,
        OP_ENABLE  = 2'd1,
        OP_DISABLE = 2'd2,
        OP_ACK     = 2'd3   // count = completions serviced
    } host_op_e;

    typedef struct packed {
        irq_src_e               src;
        logic [`IRQ_CNT_W-1:0]  count;  // completed descriptors
    } dma_event_t;

    typedef struct packed {
        host_op_e               op;
        irq_src_e               src;    // only for OP_ACK
        logic [`IRQ_CNT_W-1:0]  count;  // only for OP_ACK
    } host_cmd_t;

    typedef struct packed {
        logic     assert_n;  // active low request
        irq_src_e vector;
    } irq_req_t;

    typedef struct packed {
        logic [`IRQ_CNT_W-1:0] rx;
        logic [`IRQ_CNT_W-1:0] tx;
    } pending_t;

endpackage

//--- irq_cond_tracker.sv
////////////////////////////////////////////////////////////////////////////
// per-source pending completion counts and new-work flags
// an event that would overflow its counter is stalled via event_ready
// host acks larger than the pending count clamp to zero
////////////////////////////////////////////////////////////////////////////

`include "nic_irq_config.svh"

module irq_cond_tracker
    import irq_types_pkg::*;
    import irq_host_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dma_event_t event_in,
    input  logic       event_valid,
    output logic       event_ready,
    input  host_cmd_t  cmd,
    input  logic       cmd_valid,
    input  logic       cond_ack,
    input  irq_src_e   cond_ack_src,
    output logic       cond_rx,
    output logic       cond_tx,
    output pending_t   pending
);

    logic [`IRQ_CNT_W-1:0] cnt_rx, cnt_tx;
    logic [`IRQ_CNT_W:0]   room_sum;   // one extra bit for the carry
    logic                  ev_rx, ev_tx;
    logic                  ack_rx, ack_tx;

    // add then subtract, the add never wraps since ready guards it
    function automatic logic [`IRQ_CNT_W-1:0] next_count(
        input logic [`IRQ_CNT_W-1:0] cur,
        input logic                  add_en,
        input logic [`IRQ_CNT_W-1:0] add,
        input logic                  sub_en,
        input logic [`IRQ_CNT_W-1:0] sub
    );
        logic [`IRQ_CNT_W-1:0] sum;
        sum = add_en ? cur + add : cur;
        if (!sub_en)
            return sum;
        return (sub >= sum) ? '0 : sum - sub;  // clamp at zero
    endfunction

    // stall when the target counter has no room for the whole count
    assign room_sum    = {1'b0, (event_in.src == SRC_RX) ? cnt_rx : cnt_tx}
                         + {1'b0, event_in.count};
    assign event_ready = !room_sum[`IRQ_CNT_W];

    assign ev_rx  = event_valid && event_ready && (event_in.src == SRC_RX);
    assign ev_tx  = event_valid && event_ready && (event_in.src == SRC_TX);
    assign ack_rx = cmd_valid && (cmd.op == OP_ACK) && (cmd.src == SRC_RX);
    assign ack_tx = cmd_valid && (cmd.op == OP_ACK) && (cmd.src == SRC_TX);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_rx  <= '0;
            cnt_tx  <= '0;
            cond_rx <= 1'b0;
            cond_tx <= 1'b0;
        end else begin
            cnt_rx <= next_count(cnt_rx, ev_rx, event_in.count, ack_rx, cmd.count);
            cnt_tx <= next_count(cnt_tx, ev_tx, event_in.count, ack_tx, cmd.count);
            // new work wins over an ack in the same cycle
            if (ev_rx)
                cond_rx <= 1'b1;
            else if (cond_ack && cond_ack_src == SRC_RX)
                cond_rx <= 1'b0;
            if (ev_tx)
                cond_tx <= 1'b1;
            else if (cond_ack && cond_ack_src == SRC_TX)
                cond_tx <= 1'b0;
        end
    end

    assign pending.rx = cnt_rx;
    assign pending.tx = cnt_tx;

endmodule

//--- irq_resend_timer.sv
////////////////////////////////////////////////////////////////////////////
// idle timer for work the host has left pending
// resend_req holds until taken or until an interrupt completes
////////////////////////////////////////////////////////////////////////////

`include "nic_irq_config.svh"

module irq_resend_timer
    import irq_host_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  pending_t pending,
    input  logic     activity,    // event or host ack
    input  logic     irq_done,
    input  logic     resend_ack,
    output logic     resend_req
);

    logic [`IRQ_TMR_W-1:0] idle_cnt;
    logic                  work;

    assign work = (pending.rx != '0) || (pending.tx != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            idle_cnt   <= '0;
            resend_req <= 1'b0;
        end else if (!work) begin
            // nothing left, drop quietly
            idle_cnt   <= '0;
            resend_req <= 1'b0;
        end else if (resend_ack || irq_done) begin
            idle_cnt   <= '0;
            resend_req <= 1'b0;
        end else if (activity) begin
            idle_cnt <= '0;   // restart, a raised request stays
        end else if (!resend_req) begin
            if (idle_cnt == `IRQ_TMR_W'(`IRQ_RESEND_CYCLES - 1)) begin
                resend_req <= 1'b1;
                idle_cnt   <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

endmodule

//--- irq_gen_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// interrupt generator FSM with one request at a time on the host handshake
// rx beats tx and conditions beat resends
// a condition seen while disabled is dropped and left to the resend timer
////////////////////////////////////////////////////////////////////////////

module irq_gen_ctrl
    import irq_types_pkg::*;
    import irq_host_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  host_cmd_t cmd,
    input  logic      cmd_valid,
    input  logic      cond_rx,
    input  logic      cond_tx,
    input  pending_t  pending,
    input  logic      resend_req,
    output logic      cond_ack,
    output irq_src_e  cond_ack_src,
    output logic      resend_ack,
    output logic      irq_done,
    output irq_req_t  irq,
    input  logic      irq_rdy_n
);

    irq_state_e state;
    logic       enabled;
    logic       assert_n;
    irq_src_e   vector;      // latched with the request
    irq_src_e   resend_src;

    ////////////////////////////////////////////////////////////////////////////
    // host enable bit
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset)
            enabled <= 1'b0;
        else if (cmd_valid && cmd.op == OP_ENABLE)
            enabled <= 1'b1;
        else if (cmd_valid && cmd.op == OP_DISABLE)
            enabled <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // acks back to tracker and timer in the cycle of the decision
    ////////////////////////////////////////////////////////////////////////////

    assign cond_ack     = (state == ST_IDLE) && (cond_rx || cond_tx);
    assign cond_ack_src = cond_rx ? SRC_RX : SRC_TX;    // rx first
    assign resend_ack   = (state == ST_IDLE) && !(cond_rx || cond_tx) && resend_req;
    assign irq_done     = (state == ST_WAIT_RDY) && !irq_rdy_n;
    assign resend_src   = (pending.rx != '0) ? SRC_RX : SRC_TX;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            assert_n <= 1'b1;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (cond_ack) begin
                        vector <= cond_ack_src;
                        state  <= ST_CHECK;
                    end else if (resend_ack) begin
                        vector <= resend_src;
                        state  <= ST_RESEND;
                    end
                end
                ST_CHECK: begin
                    if (enabled) begin
                        assert_n <= 1'b0;
                        state    <= ST_WAIT_RDY;
                    end else begin
                        state <= ST_IDLE;   // dropped
                    end
                end
                ST_WAIT_RDY: begin
                    if (!irq_rdy_n) begin    // host core took it
                        assert_n <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                ST_RESEND: begin
                    if (enabled) begin       // parks here until enabled
                        assert_n <= 1'b0;
                        state    <= ST_WAIT_RDY;
                    end
                end
            endcase
        end
    end

    assign irq.assert_n = assert_n;
    assign irq.vector   = vector;

endmodule

//--- nic_irq_top.sv
////////////////////////////////////////////////////////////////////////////
// interrupt block top, tracker and timer around the generator FSM
// host commands are always taken in one cycle, no ready
////////////////////////////////////////////////////////////////////////////

module nic_irq_top
    import irq_types_pkg::*;
    import irq_host_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dma_event_t event_in,
    input  logic       event_valid,
    output logic       event_ready,
    input  host_cmd_t  cmd,
    input  logic       cmd_valid,
    output irq_req_t   irq,
    input  logic       irq_rdy_n
);

    logic     cond_rx, cond_tx;
    logic     cond_ack;
    irq_src_e cond_ack_src;
    pending_t pending;
    logic     resend_req, resend_ack, irq_done;
    logic     activity;

    // restart the idle timer on any event or host ack
    assign activity = (event_valid && event_ready) || (cmd_valid && cmd.op == OP_ACK);

    irq_cond_tracker u_tracker (
        .clk, .reset, .event_in, .event_valid, .event_ready, .cmd, .cmd_valid,
        .cond_ack, .cond_ack_src, .cond_rx, .cond_tx, .pending
    );

    irq_resend_timer u_timer (
        .clk, .reset, .pending, .activity, .irq_done, .resend_ack, .resend_req
    );

    irq_gen_ctrl u_ctrl (
        .clk, .reset, .cmd, .cmd_valid, .cond_rx, .cond_tx, .pending, .resend_req,
        .cond_ack, .cond_ack_src, .resend_ack, .irq_done, .irq, .irq_rdy_n
    );

endmodule

//--- nic_irq_assertions.sv
////////////////////////////////////////////////////////////////////////////
// handshake and FSM checks bound into every irq_gen_ctrl instance
// the vector is only checked while the request is low
////////////////////////////////////////////////////////////////////////////

module nic_irq_assertions
    import irq_types_pkg::*;
    import irq_host_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input irq_state_e state,
    input irq_req_t   irq,
    input logic       irq_rdy_n,
    input logic       cond_ack,
    input logic       resend_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // assertion failures so far

    // request low only while the FSM waits on the host core
    req_in_wait: assert property (@(posedge clk) disable iff (reset)
        !irq.assert_n |-> state == ST_WAIT_RDY)
    else begin
        $error("request low outside ST_WAIT_RDY");
        fail_count++;
    end

    vector_stable: assert property (@(posedge clk) disable iff (reset)
        !irq.assert_n |=> irq.assert_n || $stable(irq.vector))
    else begin
        $error("vector changed while request low");
        fail_count++;
    end

    // host core ready ends the request in the next cycle
    release_after_rdy: assert property (@(posedge clk) disable iff (reset)
        (!irq.assert_n && !irq_rdy_n) |=> irq.assert_n)
    else begin
        $error("request not released after irq_rdy_n");
        fail_count++;
    end

    one_ack: assert property (@(posedge clk) disable iff (reset)
        !(cond_ack && resend_ack))
    else begin
        $error("cond_ack and resend_ack in the same cycle");
        fail_count++;
    end

endmodule

bind irq_gen_ctrl nic_irq_assertions u_assert (
    .clk, .reset, .state, .irq, .irq_rdy_n, .cond_ack, .resend_ack
);

//--- nic_irq_tb.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the interrupt block with inputs on the falling edge
// tests run in order and share DUT state
// the reset test leaves rx work for the disabled resend test
////////////////////////////////////////////////////////////////////////////

`include "nic_irq_config.svh"

module nic_irq_tb
    import irq_types_pkg::*;
    import irq_host_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 3000;  // covers six tests with margin
    localparam int RESEND = `IRQ_RESEND_CYCLES;

    logic       clk;
    logic       reset;
    dma_event_t event_in;
    logic       event_valid;
    logic       event_ready;
    host_cmd_t  cmd;
    logic       cmd_valid;
    irq_req_t   irq;
    logic       irq_rdy_n;
    integer     seed = 68343;
    int         cycle_count = 0;

    nic_irq_top dut (
        .clk, .reset, .event_in, .event_valid, .event_ready, .cmd, .cmd_valid,
        .irq, .irq_rdy_n
    );

    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    ////////////////////////////////////////////////////////////////////////////
    // failure and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("[FAIL] %0t ns: %s", $time, what));
    endtask

    task automatic check_irq(input irq_src_e exp);
        if (irq.assert_n !== 1'b0)
            report_mismatch($sformatf("no request, expected vector %s", exp.name()));
        else if (irq.vector !== exp)
            report_mismatch($sformatf("vector %s, expected %s", irq.vector.name(), exp.name()));
    endtask

    task automatic check_pending(input pending_t exp);
        if (dut.pending !== exp)
            report_mismatch($sformatf("pending rx=%0d tx=%0d, expected rx=%0d tx=%0d",
                dut.pending.rx, dut.pending.tx, exp.rx, exp.tx));
    endtask

    task automatic check_ready(input logic exp);
        if (event_ready !== exp)
            report_mismatch($sformatf("event_ready=%b, expected %b", event_ready, exp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_event(input irq_src_e src, input logic [`IRQ_CNT_W-1:0] count);
        @(negedge clk);
        event_in.src   = src;
        event_in.count = count;
        event_valid    = 1'b1;
        #1 check_ready(1'b1);   // taken at the next rising edge
        @(negedge clk);
        event_valid = 1'b0;
    endtask

    task automatic send_cmd(input host_op_e op, input irq_src_e src,
                            input logic [`IRQ_CNT_W-1:0] count);
        @(negedge clk);
        cmd.op    = op;
        cmd.src   = src;
        cmd.count = count;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd.op    = OP_NOP;
    endtask

    // wait for assert_n low while counting falling edges
    task automatic wait_irq(input int max_cycles, output int waited);
        waited = 0;
        while (irq.assert_n) begin
            if (waited >= max_cycles)
                abort_run($sformatf("no interrupt request within %0d cycles", max_cycles));
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic serve_irq(input irq_src_e exp, input int hold);
        check_irq(exp);
        repeat (hold) begin     // host core busy
            @(negedge clk);
            check_irq(exp);
        end
        irq_rdy_n = 1'b0;
        @(negedge clk);
        if (irq.assert_n !== 1'b1)
            report_mismatch("request still low one cycle after irq_rdy_n went low");
        irq_rdy_n = 1'b1;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (irq.assert_n !== 1'b1)
                report_mismatch("unexpected interrupt request");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        if (irq.assert_n !== 1'b1)
            report_mismatch("request low after reset");
        check_ready(1'b1);
        check_pending('{rx: 8'd0, tx: 8'd0});
        send_event(SRC_RX, 8'd3);           // still disabled
        expect_quiet(100);
        check_pending('{rx: 8'd3, tx: 8'd0});
    endtask

    task automatic resend_after_enable();
        int waited;
        send_cmd(OP_ENABLE, SRC_RX, 8'd0);  // parked resend goes out now
        wait_irq(RESEND + 8, waited);
        serve_irq(SRC_RX, 1);
        send_cmd(OP_ACK, SRC_RX, 8'd3);
        check_pending('{rx: 8'd0, tx: 8'd0});
    endtask

    task automatic single_rx_irq();
        int waited;
        int hold;
        hold = 1 + ({$random(seed)} % 10);
        send_cmd(OP_ENABLE, SRC_RX, 8'd0);
        send_event(SRC_RX, 8'd1);
        wait_irq(4, waited);
        serve_irq(SRC_RX, hold);
        send_cmd(OP_ACK, SRC_RX, 8'd1);
        check_pending('{rx: 8'd0, tx: 8'd0});
        expect_quiet(20);                   // exactly one
    endtask

    task automatic rx_before_tx();
        int waited;
        send_event(SRC_RX, 8'd2);
        send_event(SRC_TX, 8'd4);
        wait_irq(4, waited);
        serve_irq(SRC_RX, 2);
        wait_irq(4, waited);
        serve_irq(SRC_TX, 2);
        send_cmd(OP_ACK, SRC_RX, 8'd2);
        send_cmd(OP_ACK, SRC_TX, 8'd4);
        check_pending('{rx: 8'd0, tx: 8'd0});
        expect_quiet(20);
    endtask

    task automatic resend_unacked_tx();
        int waited;
        send_event(SRC_TX, 8'd5);
        wait_irq(4, waited);
        serve_irq(SRC_TX, 1);
        wait_irq(RESEND + 8, waited);       // nothing acked so the timer repeats
        if (waited < RESEND)
            report_mismatch($sformatf("resend after %0d idle cycles", waited));
        serve_irq(SRC_TX, 1);
        send_cmd(OP_ACK, SRC_TX, 8'd5);
        check_pending('{rx: 8'd0, tx: 8'd0});
        expect_quiet(2 * RESEND);
    endtask

    task automatic fill_rx_counter();
        logic [`IRQ_CNT_W-1:0] cnt;
        pending_t              exp;
        logic                  fits;
        logic                  stalled;
        int                    model;
        int                    steps;
        model   = 0;
        steps   = 0;
        stalled = 1'b0;
        exp.tx  = '0;
        @(negedge clk);
        irq_rdy_n = 1'b0;                   // host core takes every request at once
        while (!stalled && steps < 64) begin
            cnt = 8'(1 + ({$random(seed)} % 40));
            @(negedge clk);
            event_in.src   = SRC_RX;
            event_in.count = cnt;
            event_valid    = 1'b1;
            fits = (model + int'(cnt) <= 255);
            #1 check_ready(fits);
            if (!fits) begin
                stalled = 1'b1;
                repeat (3) begin            // event waits and is not dropped
                    @(negedge clk);
                    #1 check_ready(1'b0);
                end
                exp.rx = 8'(model);
                check_pending(exp);
                @(negedge clk);
                cmd.op    = OP_ACK;
                cmd.src   = SRC_RX;
                cmd.count = cnt;            // frees exactly enough room
                cmd_valid = 1'b1;
                @(negedge clk);
                cmd_valid = 1'b0;
                cmd.op    = OP_NOP;
                model     = model - int'(cnt);
                #1 check_ready(1'b1);
            end
            @(negedge clk);
            event_valid = 1'b0;
            model       = model + int'(cnt);
            exp.rx      = 8'(model);
            check_pending(exp);
            steps++;
        end
        if (!stalled)
            abort_run("event_ready never went low while filling the rx counter");
        send_cmd(OP_ACK, SRC_RX, 8'(model));
        check_pending('{rx: 8'd0, tx: 8'd0});
        repeat (4) @(negedge clk);
        irq_rdy_n = 1'b1;
        expect_quiet(10);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        event_in    = '0;
        event_valid = 1'b0;
        cmd         = '0;
        cmd_valid   = 1'b0;
        irq_rdy_n   = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        idle_after_reset();
        resend_after_enable();
        single_rx_irq();
        rx_before_tx();
        resend_unacked_tx();
        fill_rx_counter();

        if (dut.u_ctrl.u_assert.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("%0d assertion failures", dut.u_ctrl.u_assert.fail_count));
        end
    end

endmodule

//--- nic_irq.f
+incdir+.
irq_types_pkg.sv
irq_host_pkg.sv
irq_cond_tracker.sv
irq_resend_timer.sv
irq_gen_ctrl.sv
nic_irq_top.sv
nic_irq_assertions.sv
nic_irq_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the interrupt block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f nic_irq.f \
    --top-module nic_irq_tb -Mdir obj_dir -o nic_irq_sim

status=0
./obj_dir/nic_irq_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation passed"
